// ==== compile.f ====
+incdir+hdl
hdl/scc_pkg.sv
hdl/scc_regs.sv
hdl/scc_baud_gen.sv
hdl/scc_tx.sv
hdl/scc_rx.sv
hdl/scc_irq.sv
hdl/scc_top.sv
bench/tb_scc.sv

// ==== bench/tb_scc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_scc;

	localparam int cycle_limit = 20000; // ~9.5k cycles of frames, doubled
	localparam int bit_cycles = 64; // tc 0 ticks every 4 clk, x16 mode
	localparam logic [1:0] rs_ctl = 2'b01;
	localparam logic [1:0] rs_data = 2'b11;

	logic clk;
	logic reset_hw;
	logic i_cs;
	logic i_we;
	logic [1:0] i_rs;
	logic [7:0] i_wdata;
	wire [7:0] o_rdata;
	wire o_irq_n;
	logic i_rxd;
	wire o_txd;
	logic i_cts;
	logic i_dcd;
	wire o_rts;

	integer seed;
	int errors;
	int checks;
	int cycles;

	scc_top DUT (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cs(i_cs),
		.i_we(i_we),
		.i_rs(i_rs),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_irq_n(o_irq_n),
		.i_rxd(i_rxd),
		.o_txd(o_txd),
		.i_cts(i_cts),
		.i_dcd(i_dcd),
		.o_rts(o_rts)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns
	end

	// hard stop if a wait never ends
	initial begin : watchdog
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still going after %0d clock cycles", cycles);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	// one strobe cycle, sampled by the dut on the second edge
	task automatic bus_write(input logic [1:0] rs, input logic [7:0] data);
		@(posedge clk);
		i_cs <= 1'b1;
		i_we <= 1'b1;
		i_rs <= rs;
		i_wdata <= data;
		@(posedge clk);
		i_cs <= 1'b0;
		i_we <= 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] rs, output logic [7:0] data);
		@(posedge clk);
		i_cs <= 1'b1;
		i_we <= 1'b0;
		i_rs <= rs;
		@(negedge clk);
		data = o_rdata; // mid strobe, rdata is combinational
		@(posedge clk);
		i_cs <= 1'b0;
	endtask

	// wr0 pointer write, point high for 8..15
	task automatic point_to(input logic [3:0] idx);
		if (idx != 4'd0)
			bus_write(rs_ctl, idx[3] ? {5'b00001, idx[2:0]} : {5'b00000, idx[2:0]});
	endtask

	task automatic ctl_write(input logic [3:0] idx, input logic [7:0] data);
		point_to(idx);
		bus_write(rs_ctl, data);
	endtask

	task automatic ctl_read(input logic [3:0] idx, output logic [7:0] data);
		point_to(idx);
		bus_read(rs_ctl, data);
	endtask

	task automatic poll_reg(input logic [3:0] idx, input logic [7:0] mask,
		input logic [7:0] want, input string what);
		logic [7:0] v;
		int n;
		n = 0;
		ctl_read(idx, v);
		while ((v & mask) != want && n < 400) begin
			ctl_read(idx, v);
			n++;
		end
		if ((v & mask) != want) begin
			errors++;
			$display("%s never showed up in %0d register polls", what, n);
		end
	endtask

	task automatic wait_irq(input logic level, input int max_cycles, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (o_irq_n !== level && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (o_irq_n !== level) begin
			errors++;
			$display("o_irq_n did not reach %b within %0d cycles %s", level, max_cycles, what);
		end
	endtask

	// start, data lsb first, parity, then marks for the stop bits
	function automatic logic [11:0] make_frame(input logic [7:0] data, input int nbits,
		input logic par_en, input logic par_even);
		logic [11:0] f;
		logic ones;
		f = '1;
		f[0] = 1'b0;
		ones = 1'b0;
		for (int i = 0; i < nbits; i++) begin
			f[1 + i] = data[i];
			ones = ones ^ data[i];
		end
		if (par_en)
			f[1 + nbits] = par_even ? ones : ~ones; // even: total ones even
		return f;
	endfunction

	function automatic int frame_len(input int nbits, input logic par_en, input logic two_stop);
		return 1 + nbits + int'(par_en) + (two_stop ? 2 : 1);
	endfunction

	task automatic send_serial(input logic [7:0] data, input int nbits, input logic par_en,
		input logic par_even, input logic two_stop, input logic bad_par);
		logic [11:0] f;
		int len;
		f = make_frame(data, nbits, par_en, par_even);
		if (bad_par)
			f[1 + nbits] = ~f[1 + nbits];
		len = frame_len(nbits, par_en, two_stop);
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			i_rxd <= f[i];
			repeat (bit_cycles - 1) @(posedge clk);
		end
	endtask

	task automatic capture_serial(input int len, output logic [11:0] bits);
		bits = '1;
		@(negedge clk);
		while (o_txd !== 1'b0) // start edge
			@(negedge clk);
		repeat (bit_cycles / 2) @(negedge clk); // centre of start bit
		for (int i = 0; i < len; i++) begin
			bits[i] = o_txd;
			if (i < len - 1)
				repeat (bit_cycles) @(negedge clk);
		end
	endtask

	task automatic check_reset_state();
		logic [7:0] v;
		@(negedge clk);
		check_val("o_irq_n after reset", {7'b0, o_irq_n}, 8'h01);
		check_val("o_txd after reset", {7'b0, o_txd}, 8'h01);
		check_val("o_rts after reset", {7'b0, o_rts}, 8'h00);
		ctl_read(0, v);
		check_val("rr0 tx empty after reset", v & 8'h04, 8'h04);
		ctl_read(3, v);
		check_val("rr3 after reset", v, 8'h00);
	endtask

	task automatic test_registers();
		logic [7:0] v;
		logic [7:0] tc_lo;
		logic [7:0] tc_hi;
		logic [7:0] w15;
		tc_lo = 8'($random(seed));
		tc_hi = 8'($random(seed));
		w15 = 8'($random(seed));
		ctl_read(15, v);
		check_val("rr15 after reset", v, 8'hf8);
		ctl_write(12, tc_lo);
		ctl_write(13, tc_hi);
		ctl_read(12, v);
		check_val("rr12", v, tc_lo);
		ctl_read(13, v);
		check_val("rr13", v, tc_hi);
		ctl_write(15, w15);
		ctl_read(15, v);
		check_val("rr15 readback", v, w15 & 8'hfa); // bits 2, 0 read 0
		bus_read(2'b00, v);
		check_val("channel b control read", v, 8'hff);
		bus_read(2'b10, v);
		check_val("channel b data read", v, 8'hff);
		@(posedge clk);
		i_cts <= 1'b1; // cts shows in rr0 bit 5
		ctl_read(0, v);
		check_val("rr0 cts high", v & 8'h20, 8'h20);
		@(posedge clk);
		i_cts <= 1'b0;
		ctl_read(0, v);
		check_val("rr0 cts low", v & 8'h20, 8'h00);
		ctl_write(12, 8'h00);
		ctl_write(13, 8'h00);
		ctl_write(15, 8'hf8);
		ctl_write(9, 8'h80); // restarts the divider at tc 0
	endtask

	task automatic test_transmit(input logic [7:0] wr3, input logic [7:0] wr4, input int nbits,
		input logic par_en, input logic par_even, input logic two_stop, input string name);
		logic [7:0] d;
		logic [7:0] v;
		logic [11:0] got;
		logic [11:0] exp;
		int len;
		ctl_write(3, wr3);
		ctl_write(4, wr4);
		ctl_write(5, 8'h08); // tx enable
		len = frame_len(nbits, par_en, two_stop);
		repeat (2) begin
			d = 8'($random(seed));
			exp = make_frame(d, nbits, par_en, par_even);
			bus_write(rs_data, d);
			capture_serial(len, got);
			for (int i = 0; i < len; i++) begin
				checks++;
				if (got[i] !== exp[i]) begin
					errors++;
					$display("FAIL %0t ns: %s byte %02h frame bit %0d is %b, expected %b",
						$time, name, d, i, got[i], exp[i]);
				end
			end
			ctl_read(0, v);
			check_val("rr0 tx empty after frame", v & 8'h04, 8'h04);
			poll_reg(1, 8'h01, 8'h01, "all sent");
		end
	endtask

	task automatic test_receive();
		logic [7:0] d;
		logic [7:0] v;
		ctl_write(3, 8'hc1); // 8 bits, rx on
		ctl_write(4, 8'h44); // x16, 1 stop
		repeat (2) begin
			d = 8'($random(seed));
			send_serial(d, 8, 1'b0, 1'b0, 1'b0, 1'b0);
			poll_reg(0, 8'h01, 8'h01, "rx char available");
			@(negedge clk);
			check_val("o_rts with char waiting", {7'b0, o_rts}, 8'h01);
			bus_read(rs_data, v);
			check_val("rx data", v, d);
			@(negedge clk);
			check_val("o_rts after data read", {7'b0, o_rts}, 8'h00);
		end
		ctl_write(4, 8'h47); // 8e1
		d = 8'($random(seed));
		send_serial(d, 8, 1'b1, 1'b1, 1'b0, 1'b1); // parity flipped
		poll_reg(0, 8'h01, 8'h01, "rx char with bad parity");
		ctl_read(1, v);
		check_val("rr1 parity/framing after bad parity", v & 8'h50, 8'h10);
		bus_read(rs_data, v);
		check_val("rx data with bad parity", v, d);
		ctl_read(1, v);
		check_val("rr1 parity error held", v & 8'h10, 8'h10);
		ctl_write(0, 8'h30); // error reset
		ctl_read(1, v);
		check_val("rr1 parity error after reset", v & 8'h10, 8'h00);
		ctl_write(4, 8'h44);
	endtask

	task automatic test_interrupts();
		logic [7:0] d;
		logic [7:0] v;
		ctl_write(9, 8'h08); // mie
		ctl_write(1, 8'h02); // tx int enable
		ctl_write(5, 8'h08);
		d = 8'($random(seed));
		bus_write(rs_data, d);
		wait_irq(1'b0, 2000, "after a sent character");
		ctl_read(3, v);
		check_val("rr3 with tx ip", v, 8'h10);
		ctl_write(0, 8'h28); // reset tx int pending
		wait_irq(1'b1, 4, "after tx ip reset");
		ctl_read(3, v);
		check_val("rr3 after tx ip reset", v, 8'h00);
		ctl_write(1, 8'h10); // rx int on every char
		repeat (2) begin
			d = 8'($random(seed));
			send_serial(d, 8, 1'b0, 1'b0, 1'b0, 1'b0);
			wait_irq(1'b0, 100, "after a received character");
			ctl_read(3, v);
			check_val("rr3 with rx ip", v, 8'h20);
			bus_read(rs_data, v);
			check_val("rx data under interrupt", v, d);
			wait_irq(1'b1, 4, "after the data read");
			ctl_read(3, v);
			check_val("rr3 after data read", v, 8'h00);
		end
	endtask

	task automatic test_dcd();
		logic [7:0] v;
		ctl_write(1, 8'h01); // ext int enable
		ctl_write(15, 8'h08); // dcd ie
		ctl_write(0, 8'h10); // reset ext/status, latch open
		@(posedge clk);
		i_dcd <= 1'b1;
		wait_irq(1'b0, 10, "after dcd rose");
		ctl_read(0, v);
		check_val("rr0 dcd latched high", v & 8'h08, 8'h08);
		@(posedge clk);
		i_dcd <= 1'b0;
		repeat (8) @(posedge clk);
		ctl_read(0, v);
		check_val("rr0 dcd held while pin low", v & 8'h08, 8'h08);
		@(negedge clk);
		check_val("o_irq_n still low", {7'b0, o_irq_n}, 8'h00);
		ctl_write(0, 8'h10); // release latch
		wait_irq(1'b1, 4, "after ext/status reset");
		ctl_read(0, v);
		check_val("rr0 dcd after release", v & 8'h08, 8'h00);
	endtask

	// rx int mode bits gone, so a char gives no rr3 rx ip
	task automatic receive_without_rx_ip(input string what);
		logic [7:0] d;
		logic [7:0] v;
		d = 8'($random(seed));
		send_serial(d, 8, 1'b0, 1'b0, 1'b0, 1'b0);
		poll_reg(0, 8'h01, 8'h01, "rx char after software reset");
		ctl_read(3, v);
		check_val(what, v & 8'h20, 8'h00);
		bus_read(rs_data, v);
		check_val("rx data after software reset", v, d);
	endtask

	task automatic test_soft_resets();
		logic [7:0] v;
		ctl_write(15, 8'h00);
		ctl_write(1, 8'h35); // rx every char plus bits 5, 2, 0
		ctl_write(9, 8'h80); // channel reset
		ctl_read(15, v);
		check_val("rr15 after channel reset", v, 8'h00);
		receive_without_rx_ip("rr3 rx ip after channel reset");
		ctl_write(1, 8'h35);
		ctl_write(9, 8'hc0); // full reset
		ctl_read(15, v);
		check_val("rr15 after full reset", v, 8'hf8);
		@(negedge clk);
		check_val("o_irq_n after full reset", {7'b0, o_irq_n}, 8'h01);
		check_val("o_txd after full reset", {7'b0, o_txd}, 8'h01);
		ctl_read(0, v);
		check_val("rr0 tx empty after full reset", v & 8'h04, 8'h04);
		receive_without_rx_ip("rr3 rx ip after full reset");
	endtask

	initial begin
		seed = 32'h4a4a_423d;
		errors = 0;
		checks = 0;
		reset_hw = 1'b1;
		i_cs = 1'b0;
		i_we = 1'b0;
		i_rs = rs_ctl;
		i_wdata = 8'h00;
		i_rxd = 1'b1; // line idle
		i_cts = 1'b0;
		i_dcd = 1'b0;
		repeat (4) @(posedge clk);
		reset_hw <= 1'b0;
		repeat (2) @(posedge clk);
		check_reset_state();
		test_registers();
		test_transmit(8'hc0, 8'h44, 8, 1'b0, 1'b0, 1'b0, "8n1");
		test_transmit(8'h40, 8'h4f, 7, 1'b1, 1'b1, 1'b1, "7e2");
		test_receive();
		test_interrupts();
		test_dcd();
		test_soft_resets();
		$display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/scc_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "scc_consts.svh"

module scc_top (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire [1:0] i_rs,
	input wire [`SCC_DATA_W-1:0] i_wdata,
	output logic [`SCC_DATA_W-1:0] o_rdata,
	output logic o_irq_n,
	input wire i_rxd,
	output logic o_txd,
	input wire i_cts,
	input wire i_dcd,
	output logic o_rts
);
	import scc_pkg::*;

	scc_ser_cfg_t cfg;
	scc_int_cfg_t icfg;
	scc_cmd_t cmd;
	scc_rx_stat_t rx_stat;
	scc_int_stat_t int_stat;
	logic chan_rst;
	logic tx_load;
	logic [`SCC_DATA_W-1:0] tx_data;
	logic tx_empty;
	logic tx_busy;
	logic baud_tick;

	scc_regs u_regs (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cs(i_cs),
		.i_we(i_we),
		.i_rs(i_rs),
		.i_wdata(i_wdata),
		.i_rx_stat(rx_stat),
		.i_int_stat(int_stat),
		.i_tx_empty(tx_empty),
		.i_tx_busy(tx_busy),
		.i_cts(i_cts), // straight to rr0 bit 5
		.o_rdata(o_rdata),
		.o_cfg(cfg),
		.o_icfg(icfg),
		.o_cmd(cmd),
		.o_chan_rst(chan_rst),
		.o_tx_load(tx_load),
		.o_tx_data(tx_data)
	);

	scc_baud_gen u_baud (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cfg(cfg),
		.i_chan_rst(chan_rst),
		.o_tick(baud_tick)
	);

	scc_tx u_tx (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cfg(cfg),
		.i_chan_rst(chan_rst),
		.i_tick(baud_tick),
		.i_load(tx_load),
		.i_data(tx_data),
		.o_txd(o_txd),
		.o_tx_empty(tx_empty),
		.o_tx_busy(tx_busy)
	);

	scc_rx u_rx (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_cfg(cfg),
		.i_cmd(cmd),
		.i_chan_rst(chan_rst),
		.i_tick(baud_tick),
		.i_rxd(i_rxd),
		.o_rx_stat(rx_stat)
	);

	scc_irq u_irq (
		.clk(clk),
		.reset_hw(reset_hw),
		.i_icfg(icfg),
		.i_cmd(cmd),
		.i_chan_rst(chan_rst),
		.i_tx_busy(tx_busy),
		.i_rx_avail(rx_stat.rx_avail),
		.i_dcd(i_dcd),
		.o_int_stat(int_stat),
		.o_irq_n(o_irq_n)
	);

	assign o_rts = rx_stat.rx_avail; // high while a char waits

endmodule

`default_nettype wire

// ==== hdl/scc_irq.sv ====
`timescale 1ns/10ps
`default_nettype none

module scc_irq (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::scc_int_cfg_t i_icfg,
	input wire scc_pkg::scc_cmd_t i_cmd,
	input wire i_chan_rst,
	input wire i_tx_busy,
	input wire i_rx_avail,
	input wire i_dcd,
	output scc_pkg::scc_int_stat_t o_int_stat,
	output logic o_irq_n
);
	logic tx_busy_d;
	logic tx_ip;
	logic rx_ip;
	logic rx_first; // armed for "first char" mode
	logic ext_ip;
	logic [1:0] dcd_sync;
	logic dcd_s;
	logic dcd_latch;
	logic latch_open;
	logic dcd_chg;

	assign dcd_s = dcd_sync[1];
	assign dcd_chg = latch_open & i_icfg.dcd_ie & (dcd_s != dcd_latch);

	// mode 01 first char only, 10 every char
	assign rx_ip = i_rx_avail & ((i_icfg.rx_int_mode == 2'b01 && rx_first) ||
		i_icfg.rx_int_mode == 2'b10);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			dcd_sync <= 2'b00;
			tx_busy_d <= 1'b0;
			tx_ip <= 1'b0;
			ext_ip <= 1'b0;
			rx_first <= 1'b1;
			dcd_latch <= 1'b0;
			latch_open <= 1'b1;
			o_irq_n <= 1'b1;
		end else if (i_chan_rst) begin
			tx_busy_d <= 1'b0;
			tx_ip <= 1'b0;
			ext_ip <= 1'b0;
			rx_first <= 1'b1;
			dcd_latch <= dcd_s;
			latch_open <= 1'b1;
			o_irq_n <= 1'b1;
		end else begin
			dcd_sync <= {dcd_sync[0], i_dcd};
			tx_busy_d <= i_tx_busy;
			if (i_cmd.tx_ip_reset || !i_icfg.tx_int_en)
				tx_ip <= 1'b0;
			else if (tx_busy_d && !i_tx_busy)
				tx_ip <= 1'b1; // char fully shifted out
			if (i_cmd.rx_first)
				rx_first <= 1'b1;
			else if (i_cmd.data_read)
				rx_first <= 1'b0;
			if (i_cmd.ext_reset) begin
				latch_open <= 1'b1;
				ext_ip <= 1'b0;
				dcd_latch <= dcd_s; // resync so a stale level is no change
			end else if (latch_open) begin
				dcd_latch <= dcd_s; // follows the pin while open
				if (dcd_chg) begin
					latch_open <= 1'b0;
					if (i_icfg.ext_int_en)
						ext_ip <= 1'b1;
				end
			end
			o_irq_n <= ~(i_icfg.mie & (rx_ip | tx_ip | ext_ip));
		end
	end

	assign o_int_stat = '{rx_ip: rx_ip, tx_ip: tx_ip, ext_ip: ext_ip,
		dcd_state: latch_open ? dcd_s : dcd_latch};

endmodule

`default_nettype wire

// ==== hdl/scc_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "scc_consts.svh"

module scc_rx (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::scc_ser_cfg_t i_cfg,
	input wire scc_pkg::scc_cmd_t i_cmd,
	input wire i_chan_rst,
	input wire i_tick,
	input wire i_rxd,
	output scc_pkg::scc_rx_stat_t o_rx_stat
);
	import scc_pkg::*;

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

	rx_state_e state;
	logic [1:0] sync; // [1] is safe to use
	logic rxd;
	logic [5:0] tcnt;
	logic [5:0] tlast;
	logic [5:0] target;
	logic sample; // tick at a bit centre
	logic [3:0] nbits;
	logic [3:0] bits_left;
	logic [8:0] shreg; // data + parity, enters at the top
	logic [8:0] aligned;
	logic [`SCC_DATA_W-1:0] dmask;
	logic [`SCC_DATA_W-1:0] rdata;
	logic par_bad;
	logic rx_avail;
	logic [`SCC_DATA_W-1:0] rx_data;
	logic parity_err;
	logic frame_err;

	assign rxd = sync[1];
	assign nbits = char_bits(i_cfg.bits_per_char);
	assign tlast = tick_last(i_cfg.clk_mode);
	assign target = (state == st_start) ? tlast >> 1 : tlast; // half a bit to confirm start
	assign sample = i_tick && tcnt == target;

	assign aligned = shreg >> (4'd9 - nbits - i_cfg.parity_en);
	assign dmask = 8'hff >> (4'd8 - nbits);
	assign rdata = aligned[7:0] & dmask;
	assign par_bad = i_cfg.parity_en & (^rdata ^ aligned[nbits] ^ ~i_cfg.parity_even);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			sync <= 2'b11;
			state <= st_idle;
			tcnt <= '0;
			bits_left <= '0;
			rx_avail <= 1'b0;
			parity_err <= 1'b0;
			frame_err <= 1'b0;
		end else if (i_chan_rst) begin
			state <= st_idle;
			tcnt <= '0;
			rx_avail <= 1'b0;
			parity_err <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			sync <= {sync[0], i_rxd};
			if (i_cmd.data_read)
				rx_avail <= 1'b0;
			if (i_cmd.err_reset) begin
				parity_err <= 1'b0;
				frame_err <= 1'b0;
			end
			if (!i_cfg.rx_en)
				state <= st_idle;
			else if (i_tick) begin
				tcnt <= sample ? 6'd0 : tcnt + 1'b1;
				case (state)
					st_idle: begin
						tcnt <= '0;
						if (!rxd) begin // falling edge of start
							state <= (tlast == '0) ? st_data : st_start; // x1 skips the check
							bits_left <= nbits + i_cfg.parity_en;
						end
					end
					st_start: if (sample)
						state <= rxd ? st_idle : st_data; // glitch, back to hunt
					st_data: if (sample) begin
						bits_left <= bits_left - 1'b1;
						if (bits_left == 4'd1)
							state <= st_stop;
					end
					st_stop: if (sample) begin
						state <= st_idle;
						rx_avail <= 1'b1; // wins over a read on the same edge
						parity_err <= parity_err | par_bad; // sticky
						frame_err <= frame_err | ~rxd;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_data && sample)
			shreg <= {rxd, shreg[8:1]};
		if (state == st_stop && sample)
			rx_data <= rdata; // unread char is lost
	end

	assign o_rx_stat = '{rx_avail: rx_avail, rx_data: rx_data,
		parity_err: parity_err, frame_err: frame_err};

endmodule

`default_nettype wire

// ==== hdl/scc_tx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "scc_consts.svh"

module scc_tx (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::scc_ser_cfg_t i_cfg,
	input wire i_chan_rst,
	input wire i_tick,
	input wire i_load,
	input wire [`SCC_DATA_W-1:0] i_data,
	output logic o_txd,
	output logic o_tx_empty,
	output logic o_tx_busy
);
	import scc_pkg::*;

	logic buf_full;
	logic [`SCC_DATA_W-1:0] buf_data; // holding buffer
	logic busy;
	logic [10:0] sh; // bits after the current one, lsb first
	logic [3:0] bits_left; // incl. the bit on the line
	logic [5:0] tcnt;
	logic [5:0] tlast;
	logic [3:0] nbits;
	logic [`SCC_DATA_W-1:0] dmask;
	logic [`SCC_DATA_W-1:0] dbits;
	logic par;
	logic [10:0] frame;
	logic [3:0] frame_len;
	logic start;
	logic bit_done;

	assign nbits = char_bits(i_cfg.bits_per_char);
	assign tlast = tick_last(i_cfg.clk_mode);
	assign dmask = 8'hff >> (4'd8 - nbits);
	assign dbits = buf_data & dmask;
	assign par = ^dbits ^ ~i_cfg.parity_even;
	assign frame_len = 4'd2 + nbits + i_cfg.parity_en + i_cfg.two_stop;

	always_comb begin
		frame = {3'b111, dbits | ~dmask}; // marks above the data
		if (i_cfg.parity_en)
			frame[nbits] = par;
	end

	assign start = i_tick & ~busy & buf_full & i_cfg.tx_en;
	assign bit_done = busy & i_tick & (tcnt == tlast);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			buf_full <= 1'b0;
			busy <= 1'b0;
			o_txd <= 1'b1;
			tcnt <= '0;
			bits_left <= '0;
		end else if (i_chan_rst) begin
			buf_full <= 1'b0;
			busy <= 1'b0;
			o_txd <= 1'b1;
			tcnt <= '0;
			bits_left <= '0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				buf_full <= 1'b0;
				o_txd <= 1'b0; // start bit
				bits_left <= frame_len;
				tcnt <= '0;
			end else if (busy && i_tick) begin
				tcnt <= bit_done ? 6'd0 : tcnt + 1'b1;
				if (bit_done) begin
					bits_left <= bits_left - 1'b1;
					if (bits_left == 4'd1) begin
						busy <= 1'b0; // last stop bit done
						o_txd <= 1'b1;
					end else
						o_txd <= sh[0];
				end
			end
			if (i_load)
				buf_full <= 1'b1; // a waiting byte is overwritten
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			sh <= frame;
		else if (bit_done)
			sh <= {1'b1, sh[10:1]};
		if (i_load)
			buf_data <= i_data;
	end

	assign o_tx_empty = ~buf_full;
	assign o_tx_busy = busy;

	// line rests at mark between frames
	a_idle_mark: assert property (@(posedge clk) disable iff (reset_hw)
		!busy |-> o_txd);

endmodule

`default_nettype wire

// ==== hdl/scc_baud_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module scc_baud_gen (
	input wire clk,
	input wire reset_hw,
	input wire scc_pkg::scc_ser_cfg_t i_cfg,
	input wire i_chan_rst,
	output logic o_tick
);
	logic [17:0] cnt;
	logic [17:0] reload;

	// period 2 * (tc + 2) clocks
	assign reload = {{1'b0, i_cfg.time_const} + 17'd2, 1'b0} - 18'd1;

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else if (i_chan_rst) begin
			cnt <= reload; // restart a full period
			o_tick <= 1'b0;
		end else begin
			o_tick <= cnt == '0;
			if (cnt == '0)
				cnt <= reload; // new tc seen here only
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/scc_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "scc_consts.svh"

module scc_regs (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire [1:0] i_rs, // [1] data/ctl, [0] must be 1 for channel a
	input wire [`SCC_DATA_W-1:0] i_wdata,
	input wire scc_pkg::scc_rx_stat_t i_rx_stat,
	input wire scc_pkg::scc_int_stat_t i_int_stat,
	input wire i_tx_empty,
	input wire i_tx_busy,
	input wire i_cts,
	output logic [`SCC_DATA_W-1:0] o_rdata,
	output scc_pkg::scc_ser_cfg_t o_cfg,
	output scc_pkg::scc_int_cfg_t o_icfg,
	output scc_pkg::scc_cmd_t o_cmd,
	output logic o_chan_rst,
	output logic o_tx_load,
	output logic [`SCC_DATA_W-1:0] o_tx_data
);
	import scc_pkg::*;

	scc_idx_t ptr; // pointer used by the current access
	scc_idx_t ptr_next; // takes over once cs drops
	scc_wr0_cmd_e wr0_cmd;
	logic ctl_acc;
	logic ctl_wr;
	logic data_acc;
	logic cmd_wr;
	logic rst_full;
	logic mie; // wr9 bit 3, the only wr9 bit kept
	logic [`SCC_DATA_W-1:0] wr1, wr3, wr4, wr5, wr12, wr13, wr15;
	logic [`SCC_DATA_W-1:0] rr0, rr1, rr3, rr15;

	assign ctl_acc = i_cs & ~i_rs[1] & i_rs[0];
	assign ctl_wr = ctl_acc & i_we;
	assign data_acc = i_cs & i_rs[1] & i_rs[0];
	assign cmd_wr = ctl_wr && ptr == `SCC_R0;
	assign wr0_cmd = scc_wr0_cmd_e'(i_wdata[5:3]);

	// wr9 7:6, 11 full reset, 10 channel reset, 01 is channel b
	assign rst_full = ctl_wr && ptr == `SCC_R9 && i_wdata[7:6] == 2'b11;
	assign o_chan_rst = rst_full | (ctl_wr && ptr == `SCC_R9 && i_wdata[7:6] == 2'b10);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			ptr <= '0;
			ptr_next <= '0;
		end else begin
			if (!i_cs)
				ptr <= ptr_next; // rdata stays stable during the strobe
			if (ctl_acc) begin
				ptr_next <= '0; // any ctl access returns to wr0
				if (i_we && ptr == `SCC_R0)
					ptr_next <= {wr0_cmd == cmd_point_high, i_wdata[2:0]};
			end
		end
	end

	// wr1/wr5 obey both software resets
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			wr1 <= '0;
			wr5 <= '0;
		end else if (rst_full) begin
			wr1 <= '0;
			wr5 <= '0;
		end else if (o_chan_rst) begin
			wr1 <= wr1 & `SCC_WR1_KEEP;
			wr5 <= wr5 & `SCC_WR5_KEEP;
		end else if (ctl_wr) begin
			if (ptr == `SCC_R1)
				wr1 <= i_wdata;
			if (ptr == `SCC_R5)
				wr5 <= i_wdata;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			wr3 <= '0;
			wr4 <= '0;
			wr12 <= '0;
			wr13 <= '0;
			wr15 <= `SCC_WR15_RST;
			mie <= 1'b0;
		end else if (ctl_wr) begin
			case (ptr)
				`SCC_R3: wr3 <= i_wdata;
				`SCC_R4: wr4 <= i_wdata;
				`SCC_R12: wr12 <= i_wdata;
				`SCC_R13: wr13 <= i_wdata;
				`SCC_R15: wr15 <= i_wdata;
				`SCC_R9: begin
					mie <= i_wdata[3]; // reset codes come with the same write
					if (rst_full)
						wr15 <= `SCC_WR15_RST;
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		o_cfg.bits_per_char = wr3[7:6];
		o_cfg.parity_en = wr4[0];
		o_cfg.parity_even = wr4[1];
		o_cfg.two_stop = wr4[3:2] == 2'b11; // 1.5 stop treated as one
		o_cfg.clk_mode = wr4[7:6];
		o_cfg.rx_en = wr3[0];
		o_cfg.tx_en = wr5[3];
		o_cfg.time_const = {wr13, wr12};
		o_cfg.rsvd = '0;
		o_icfg.rx_int_mode = wr3[0] ? wr1[4:3] : 2'b00; // no rx irq while rx off
		o_icfg.tx_int_en = wr1[1] & wr5[3];
		o_icfg.ext_int_en = wr1[0];
		o_icfg.dcd_ie = wr15[3];
		o_icfg.mie = mie;
	end

	always_comb begin
		o_cmd.ext_reset = cmd_wr && wr0_cmd == cmd_ext_reset;
		// reset highest ius only ever has the tx source to clear
		o_cmd.tx_ip_reset = cmd_wr && (wr0_cmd == cmd_tx_ip_reset || wr0_cmd == cmd_reset_ius);
		o_cmd.rx_first = cmd_wr && wr0_cmd == cmd_rx_first;
		o_cmd.err_reset = cmd_wr && wr0_cmd == cmd_err_reset;
		o_cmd.data_read = data_acc & ~i_we;
	end

	assign o_tx_load = data_acc & i_we;
	assign o_tx_data = i_wdata;

	assign rr0 = {1'b0, 1'b1, i_cts, 1'b0, // break, underrun, cts, hunt
		i_int_stat.dcd_state, i_tx_empty, 1'b0, i_rx_stat.rx_avail};
	assign rr1 = {1'b0, i_rx_stat.frame_err, 1'b0, i_rx_stat.parity_err,
		`SCC_RR1_RESIDUE, ~i_tx_busy}; // all sent
	assign rr3 = {2'b00, i_int_stat.rx_ip, i_int_stat.tx_ip, i_int_stat.ext_ip, 3'b000};
	assign rr15 = {wr15[7:3], 1'b0, wr15[1], 1'b0};

	// images of rr0..3 at 4..7, as on the real part
	always_comb begin
		if (!i_rs[0])
			o_rdata = '1; // channel b absent
		else if (i_rs[1])
			o_rdata = i_rx_stat.rx_data;
		else begin
			case (ptr)
				`SCC_R0, 4'd4: o_rdata = rr0;
				`SCC_R1, 4'd5: o_rdata = rr1;
				`SCC_R3, 4'd7: o_rdata = rr3;
				4'd8: o_rdata = i_rx_stat.rx_data;
				`SCC_R9, `SCC_R13: o_rdata = wr13;
				`SCC_R12: o_rdata = wr12;
				4'd11, `SCC_R15: o_rdata = rr15;
				default: o_rdata = '0;
			endcase
		end
	end

	// pointer only moves between strobes
	a_ptr_hold: assert property (@(posedge clk) disable iff (reset_hw)
		i_cs |=> $stable(ptr));

endmodule

`default_nettype wire

// ==== hdl/scc_pkg.sv ====
`default_nettype none
`include "scc_consts.svh"

package scc_pkg;

	typedef logic [`SCC_IDX_W-1:0] scc_idx_t;

	// wr0 bits 5:3, 011 (send abort) not handled
	typedef enum logic [2:0] {
		cmd_null = 3'b000,
		cmd_point_high = 3'b001,
		cmd_ext_reset = 3'b010,
		cmd_rx_first = 3'b100,
		cmd_tx_ip_reset = 3'b101,
		cmd_err_reset = 3'b110,
		cmd_reset_ius = 3'b111
	} scc_wr0_cmd_e;

	typedef struct packed {
		logic [1:0] bits_per_char; // wr3 7:6 encoding
		logic parity_en;
		logic parity_even;
		logic two_stop;
		logic [1:0] clk_mode; // x1 x16 x32 x64
		logic rx_en;
		logic tx_en;
		logic [15:0] time_const; // {wr13, wr12}
		logic [2:0] rsvd;
	} scc_ser_cfg_t;

	typedef struct packed {
		logic [1:0] rx_int_mode; // wr1 4:3
		logic tx_int_en;
		logic ext_int_en;
		logic dcd_ie;
		logic mie;
	} scc_int_cfg_t;

	// single cycle strobes
	typedef struct packed {
		logic ext_reset;
		logic tx_ip_reset;
		logic rx_first;
		logic err_reset;
		logic data_read;
	} scc_cmd_t;

	typedef struct packed {
		logic rx_avail;
		logic [`SCC_DATA_W-1:0] rx_data;
		logic parity_err;
		logic frame_err;
	} scc_rx_stat_t;

	typedef struct packed {
		logic rx_ip;
		logic tx_ip;
		logic ext_ip;
		logic dcd_state; // latched or live dcd
	} scc_int_stat_t;

	// 00=5 01=7 10=6 11=8, same coding as the chip
	function automatic logic [3:0] char_bits(input logic [1:0] enc);
		case (enc)
			2'b00: return 4'd5;
			2'b01: return 4'd7;
			2'b10: return 4'd6;
			default: return 4'd8;
		endcase
	endfunction

	// ticks per bit minus one
	function automatic logic [5:0] tick_last(input logic [1:0] mode);
		case (mode)
			2'b00: return 6'd0;
			2'b01: return 6'd15;
			2'b10: return 6'd31;
			default: return 6'd63;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hdl/scc_consts.svh ====
`ifndef SCC_CONSTS_SVH
`define SCC_CONSTS_SVH

// bus and register width
`define SCC_DATA_W 8
`define SCC_IDX_W 4 // wr0 pointer, point high gives 8..15

`define SCC_WR15_RST 8'hf8 // all ext/status enables set
// bits a channel reset leaves alone
`define SCC_WR1_KEEP 8'h24 // bits 5, 2
`define SCC_WR5_KEEP 8'h61 // bits 6, 5, 0
`define SCC_RR1_RESIDUE 3'b011 // async mode, fixed code

// register indices
`define SCC_R0 4'd0
`define SCC_R1 4'd1
`define SCC_R3 4'd3
`define SCC_R4 4'd4
`define SCC_R5 4'd5
`define SCC_R9 4'd9
`define SCC_R12 4'd12
`define SCC_R13 4'd13
`define SCC_R15 4'd15

`endif
